/* verilog/memPkg.sv */
`default_nettype none

package memPkg;

    localparam int ADDR_W    = 12;
    localparam int RAM_DEPTH = 4096;
    localparam int WORD_W    = 32;

    typedef logic [ADDR_W-1:0] addr_t;

    // access length, LEN_WORD means four bytes
    typedef logic [1:0] lenCode_t;
    localparam lenCode_t LEN_BYTE = 2'd1;
    localparam lenCode_t LEN_HALF = 2'd2;
    localparam lenCode_t LEN_WORD = 2'd3;

    // lane 0 is the least significant byte
    typedef union packed {
        logic [WORD_W-1:0] word;
        logic [3:0][7:0]   bytes;
    } memWord;

    // one byte command to the RAM
    typedef struct packed {
        logic       en;
        logic       write;
        addr_t      addr;
        logic [7:0] wdata;
    } ramCmd_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } fetchReq_t;

    typedef struct packed {
        logic   done;
        memWord inst;
    } fetchResp_t;

    typedef struct packed {
        logic     en;
        logic     isStore;
        lenCode_t len;
        addr_t    addr;
        memWord   wdata;
    } dataReq_t;

    typedef struct packed {
        logic   done;
        memWord rdata;
    } dataResp_t;

endpackage

`default_nettype wire

/* verilog/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic            clk,
    input  memPkg::ramCmd_t cmd,
    output logic [7:0]      rdata
);
    import memPkg::*;

    logic [7:0] mem [RAM_DEPTH];

    // read byte only changes on a read command
    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.write) begin
                mem[cmd.addr] <= cmd.wdata;
            end else begin
                rdata <= mem[cmd.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/instFetchSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module instFetchSeq (
    input  logic               clk,
    input  logic               rst,
    input  logic               hold,
    input  logic               grant,
    input  memPkg::fetchReq_t  req,
    input  logic [7:0]         ramRdata,
    output memPkg::ramCmd_t    cmd,
    output logic               busy,
    output memPkg::fetchResp_t resp
);
    import memPkg::*;

    // stage 0..3 issue byte reads, stage 4 takes the last byte
    logic [2:0]      stage;
    logic [1:0]      captLane;
    logic [2:0][7:0] lowBytes;
    logic            active;
    logic            lastStage;

    assign active    = grant && req.en;
    assign busy      = active;
    assign lastStage = (stage == 3'd4);
    assign captLane  = 2'(stage - 3'd1);

    always_comb begin
        cmd       = '0;
        cmd.en    = active && !hold && !lastStage;
        cmd.write = 1'b0;
        cmd.addr  = req.addr + addr_t'(stage);
    end

    // byte 3 comes straight from the RAM output
    always_comb begin
        resp               = '0;
        resp.done          = active && !hold && lastStage;
        resp.inst.bytes[0] = lowBytes[0];
        resp.inst.bytes[1] = lowBytes[1];
        resp.inst.bytes[2] = lowBytes[2];
        resp.inst.bytes[3] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (resp.done) begin
            stage <= '0;
        end else if (active && !hold) begin
            stage <= stage + 3'd1;
        end
    end

    // returning byte is taken even while held, rdata stays put meanwhile
    always_ff @(posedge clk) begin
        if (active && stage != 3'd0 && !lastStage) begin
            lowBytes[captLane] <= ramRdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/dataAccessSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module dataAccessSeq (
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,
    input  logic              grant,
    input  memPkg::dataReq_t  req,
    input  logic [7:0]        ramRdata,
    output memPkg::ramCmd_t   cmd,
    output logic              busy,
    output memPkg::dataResp_t resp
);
    import memPkg::*;

    dataReq_t        cur;
    logic [2:0]      stage;
    logic [2:0]      byteCount;
    logic [1:0]      lastLane;
    logic [1:0]      captLane;
    logic [2:0][7:0] lowBytes;
    logic            active;
    logic            lastStage;

    // request sampled while not owning the port
    always_ff @(posedge clk) begin
        if (!grant) begin
            cur <= req;
        end
    end

    assign active = grant && cur.en;
    assign busy   = active;

    always_comb begin
        case (cur.len)
            LEN_BYTE: byteCount = 3'd1;
            LEN_HALF: byteCount = 3'd2;
            default:  byteCount = 3'd4;
        endcase
    end

    assign lastLane = 2'(byteCount - 3'd1);
    assign captLane = 2'(stage - 3'd1);

    // stores end with the last write, loads one cycle later
    assign lastStage = cur.isStore ? (stage == byteCount - 3'd1) : (stage == byteCount);

    always_comb begin
        cmd       = '0;
        cmd.en    = active && !hold && (stage < byteCount);
        cmd.write = cur.isStore;
        cmd.addr  = cur.addr + addr_t'(stage);
        cmd.wdata = cur.wdata.bytes[stage[1:0]];
    end

    // zero-extended load result, last lane from the RAM output
    always_comb begin
        resp      = '0;
        resp.done = active && !hold && lastStage;
        if (!cur.isStore) begin
            for (int i = 0; i < 3; i++) begin
                if (3'(i) < byteCount - 3'd1) begin
                    resp.rdata.bytes[i] = lowBytes[i];
                end
            end
            resp.rdata.bytes[lastLane] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (resp.done) begin
            stage <= '0;
        end else if (active && !hold) begin
            stage <= stage + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (active && !cur.isStore && stage != 3'd0 && stage < byteCount) begin
            lowBytes[captLane] <= ramRdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/memPortArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memPortArbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            hold,
    input  logic            fetchEn,
    input  logic            dataEn,
    input  logic            fetchDone,
    input  logic            dataDone,
    input  memPkg::ramCmd_t fetchCmd,
    input  memPkg::ramCmd_t dataCmd,
    output logic            fetchGrant,
    output logic            dataGrant,
    output memPkg::ramCmd_t ramCmd
);
    import memPkg::*;

    ramCmd_t selCmd;

    // the two grant bits are the owner state
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchGrant <= 1'b0;
            dataGrant  <= 1'b0;
        end else if (!hold) begin
            if (dataGrant) begin
                if (dataDone) begin
                    dataGrant <= 1'b0;
                end
            end else if (fetchGrant) begin
                if (fetchDone) begin
                    fetchGrant <= 1'b0;
                end
            end else begin
                // data wins over fetch
                if (dataEn) begin
                    dataGrant <= 1'b1;
                end else if (fetchEn) begin
                    fetchGrant <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        if (dataGrant) begin
            selCmd = dataCmd;
        end else if (fetchGrant) begin
            selCmd = fetchCmd;
        end else begin
            selCmd = '0;
        end
    end

    // nothing reaches the RAM while held
    always_comb begin
        ramCmd    = selCmd;
        ramCmd.en = selCmd.en && !hold;
    end

endmodule

`default_nettype wire

/* verilog/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               hold,
    input  memPkg::fetchReq_t  fetchReq,
    output memPkg::fetchResp_t fetchResp,
    input  memPkg::dataReq_t   dataReq,
    output memPkg::dataResp_t  dataResp
);
    import memPkg::*;

    ramCmd_t    fetchCmd;
    ramCmd_t    dataCmd;
    ramCmd_t    ramCmd;
    logic [7:0] ramRdata;
    logic       fetchGrant;
    logic       dataGrant;

    instFetchSeq i_instFetchSeq (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .grant    (fetchGrant),
        .req      (fetchReq),
        .ramRdata (ramRdata),
        .cmd      (fetchCmd),
        .busy     (),
        .resp     (fetchResp)
    );

    dataAccessSeq i_dataAccessSeq (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .grant    (dataGrant),
        .req      (dataReq),
        .ramRdata (ramRdata),
        .cmd      (dataCmd),
        .busy     (),
        .resp     (dataResp)
    );

    memPortArbiter i_memPortArbiter (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .fetchEn    (fetchReq.en),
        .dataEn     (dataReq.en),
        .fetchDone  (fetchResp.done),
        .dataDone   (dataResp.done),
        .fetchCmd   (fetchCmd),
        .dataCmd    (dataCmd),
        .fetchGrant (fetchGrant),
        .dataGrant  (dataGrant),
        .ramCmd     (ramCmd)
    );

    byteRam i_byteRam (
        .clk   (clk),
        .cmd   (ramCmd),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

/* testbench/memSubsystem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module arbiterChk (
    input logic            clk,
    input logic            rst,
    input logic            hold,
    input logic            fetchDone,
    input logic            dataDone,
    input logic            fetchGrant,
    input logic            dataGrant,
    input memPkg::ramCmd_t fetchCmd,
    input memPkg::ramCmd_t dataCmd,
    input memPkg::ramCmd_t ramCmd
);
    int failCount = 0;

    grantsExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchGrant && dataGrant))
        else begin
            $error("fetch and data grant high together");
            failCount++;
        end

    // sequencer commands must be quiet too, not only the muxed one
    holdBlocksRam: assert property (@(posedge clk) disable iff (rst)
        hold |-> !(ramCmd.en || fetchCmd.en || dataCmd.en))
        else begin
            $error("RAM command issued while hold is high");
            failCount++;
        end

    writeOnlyForData: assert property (@(posedge clk) disable iff (rst)
        (ramCmd.en && ramCmd.write) |-> dataGrant)
        else begin
            $error("RAM write without data grant");
            failCount++;
        end

    // one idle cycle after every done
    idleAfterDone: assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> (!fetchGrant && !dataGrant))
        else begin
            $error("grant present in the cycle after a done");
            failCount++;
        end

endmodule

bind memPortArbiter arbiterChk arbChk (
    .clk        (clk),
    .rst        (rst),
    .hold       (hold),
    .fetchDone  (fetchDone),
    .dataDone   (dataDone),
    .fetchGrant (fetchGrant),
    .dataGrant  (dataGrant),
    .fetchCmd   (fetchCmd),
    .dataCmd    (dataCmd),
    .ramCmd     (ramCmd)
);

`default_nettype wire

/* testbench/tbMemSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMemSubsystem;
    import memPkg::*;

    logic       clk = 1'b0;
    logic       rst;
    logic       hold = 1'b0;
    logic       holdOn;
    fetchReq_t  fetchReq;
    fetchResp_t fetchResp;
    dataReq_t   dataReq;
    dataResp_t  dataResp;

    integer seed = 32'hf6b0;
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    int     timeoutLimit = 4000;
    int     asrtFails;

    int          vecOp[$];
    int          vecLen[$];
    logic [31:0] vecAddr[$];
    logic [31:0] vecWdata[$];
    logic [31:0] vecExp[$];

    memSubsystem i_memSubsystem (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .fetchReq  (fetchReq),
        .fetchResp (fetchResp),
        .dataReq   (dataReq),
        .dataResp  (dataResp)
    );

    always #2 clk = ~clk;

    // roughly one held cycle in four once enabled
    always @(posedge clk) begin
        hold <= holdOn && (($random(seed) & 32'h3) == 32'h0);
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout after %0d cycles, the run did not complete", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic checkVal(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic int byteCountOf(input int lenCode);
        if (lenCode == 1) begin
            return 1;
        end else if (lenCode == 2) begin
            return 2;
        end
        return 4;
    endfunction

    function automatic logic [31:0] laneMask(input int nBytes);
        if (nBytes >= 4) begin
            return 32'hffff_ffff;
        end
        return (32'h1 << (8 * nBytes)) - 32'h1;
    endfunction

    task automatic loadVectors();
        int          fd;
        int          got;
        int          op;
        int          len;
        string       line;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        fd = $fopen("testbench/memctrl_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/memctrl_testdata.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 0 && line[0] != "#") begin
                got = $sscanf(line, "%d %h %d %h %h", op, addr, len, wdata, exp);
                if (got == 5) begin
                    vecOp.push_back(op);
                    vecAddr.push_back(addr);
                    vecLen.push_back(len);
                    vecWdata.push_back(wdata);
                    vecExp.push_back(exp);
                end
            end
        end
        $fclose(fd);
    endtask

    // op 0 fetch, 1 load, 2 store, 3 fetch and load together
    task automatic runVector(input int idx, input bit timed);
        int          op;
        int          nBytes;
        int          cycles;
        int          dataLat;
        int          fetchLat;
        bit          dataPending;
        bit          fetchPending;
        bit          dataWasPending;
        logic [31:0] loadExp;
        dataReq_t    dReq;
        fetchReq_t   fReq;
        op           = vecOp[idx];
        nBytes       = byteCountOf(vecLen[idx]);
        dataPending  = (op != 0);
        fetchPending = (op == 0 || op == 3);
        loadExp      = (op == 3) ? (vecExp[idx] & laneMask(nBytes)) : vecExp[idx];
        dataLat      = (op == 2) ? nBytes : nBytes + 1;
        // fetch waits for the load plus one idle cycle
        fetchLat     = (op == 3) ? nBytes + 7 : 5;

        dReq            = '0;
        dReq.en         = dataPending;
        dReq.isStore    = (op == 2);
        dReq.len        = lenCode_t'(vecLen[idx]);
        dReq.addr       = addr_t'(vecAddr[idx]);
        dReq.wdata.word = vecWdata[idx];
        fReq            = '0;
        fReq.en         = fetchPending;
        fReq.addr       = addr_t'(vecAddr[idx]);

        @(posedge clk);
        dataReq  <= dReq;
        fetchReq <= fReq;
        cycles = 0;
        while (dataPending || fetchPending) begin
            @(negedge clk);
            dataWasPending = dataPending;
            if (dataPending && dataResp.done) begin
                if (op != 2) begin
                    checkVal("dataResp.rdata", dataResp.rdata.word, loadExp);
                end
                if (timed) begin
                    checkVal("data latency", cycles, dataLat);
                end
                dataPending = 1'b0;
                dReq.en = 1'b0;
            end else if (!dataPending) begin
                checkVal("dataResp.done", 32'(dataResp.done), 32'd0);
            end
            if (fetchPending && fetchResp.done) begin
                if (dataWasPending) begin
                    $display("fetch done arrived before data done at %0t", $time);
                    errorCount++;
                end
                checkVal("fetchResp.inst", fetchResp.inst.word, vecExp[idx]);
                if (timed) begin
                    checkVal("fetch latency", cycles, fetchLat);
                end
                fetchPending = 1'b0;
                fReq.en = 1'b0;
            end else if (!fetchPending) begin
                checkVal("fetchResp.done", 32'(fetchResp.done), 32'd0);
            end
            // give up on this vector after 40 cycles
            if (cycles >= 40 && (dataPending || fetchPending)) begin
                if (dataPending) begin
                    $display("data done never arrived for vector %0d", idx);
                end
                if (fetchPending) begin
                    $display("fetch done never arrived for vector %0d", idx);
                end
                errorCount++;
                dataPending  = 1'b0;
                fetchPending = 1'b0;
                dReq.en      = 1'b0;
                fReq.en      = 1'b0;
            end
            cycles++;
            @(posedge clk);
            dataReq  <= dReq;
            fetchReq <= fReq;
        end
        @(negedge clk);
        checkVal("dataResp.done", 32'(dataResp.done), 32'd0);
        checkVal("fetchResp.done", 32'(fetchResp.done), 32'd0);
    endtask

    initial begin
        rst      = 1'b1;
        holdOn   = 1'b0;
        fetchReq = '0;
        dataReq  = '0;
        loadVectors();
        timeoutLimit = (vecOp.size() + 1) * 40;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // exact latencies first, then the same sequence under random hold
        for (int i = 0; i < vecOp.size(); i++) begin
            runVector(i, 1'b1);
        end
        @(posedge clk);
        holdOn <= 1'b1;
        for (int i = 0; i < vecOp.size(); i++) begin
            runVector(i, 1'b0);
        end
        repeat (2) @(posedge clk);

        asrtFails = i_memSubsystem.i_memPortArbiter.arbChk.failCount;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errorCount, asrtFails);
        if (errorCount == 0 && asrtFails == 0 && vecOp.size() > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* memctrl.f */
verilog/memPkg.sv
verilog/byteRam.sv
verilog/instFetchSeq.sv
verilog/dataAccessSeq.sv
verilog/memPortArbiter.sv
verilog/memSubsystem.sv
testbench/memSubsystem_chk.sv
testbench/tbMemSubsystem.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

objDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tbMemSubsystem \
    -Mdir "$objDir" \
    -f memctrl.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let the run continue past assertion failures so the testbench can count them
"./$objDir/VtbMemSubsystem" +verilator+error+limit+100 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Result: PASSED$" "$logFile"; then
    exit 0
fi
exit 1

/* testbench/memctrl_testdata.txt */
# op: 0 fetch, 1 load, 2 store, 3 fetch and load in the same cycle
# op addr(hex) len(1 byte, 2 half, 3 word) wdata(hex) expected(hex)
2 100 3 deadbeef 00000000
0 100 0 00000000 deadbeef
2 104 3 12345678 00000000
2 108 3 a5c3f00f 00000000
2 ffc 3 cafef00d 00000000
1 104 1 00000000 00000078
1 104 2 00000000 00005678
1 104 3 00000000 12345678
1 106 2 00000000 00001234
1 107 1 00000000 00000012
2 108 1 00000077 00000000
2 10a 2 00009911 00000000
1 108 3 00000000 9911f077
0 104 0 00000000 12345678
3 100 3 00000000 deadbeef
3 104 1 00000000 12345678
0 ffc 0 00000000 cafef00d
1 ffe 2 00000000 0000cafe
2 200 2 0000beef 00000000
1 200 2 00000000 0000beef
3 108 2 00000000 9911f077
